// ==== logic/rv32iPkg.sv ====
package rv32iPkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int regDepth     = 32;
    localparam int aluOpWidth   = 4;

    //////////////////////////////////////////////////
    // ALU operation codes
    //////////////////////////////////////////////////
    localparam logic [aluOpWidth-1:0] aluOpAdd   = 4'd0;
    localparam logic [aluOpWidth-1:0] aluOpSub   = 4'd1;
    localparam logic [aluOpWidth-1:0] aluOpSll   = 4'd2;
    localparam logic [aluOpWidth-1:0] aluOpSlt   = 4'd3;
    localparam logic [aluOpWidth-1:0] aluOpSltu  = 4'd4;
    localparam logic [aluOpWidth-1:0] aluOpXor   = 4'd5;
    localparam logic [aluOpWidth-1:0] aluOpSrl   = 4'd6;
    localparam logic [aluOpWidth-1:0] aluOpSra   = 4'd7;
    localparam logic [aluOpWidth-1:0] aluOpOr    = 4'd8;
    localparam logic [aluOpWidth-1:0] aluOpAnd   = 4'd9;
    // Result is operand B, used by LUI
    localparam logic [aluOpWidth-1:0] aluOpPassB = 4'd10;

    //////////////////////////////////////////////////
    // Major opcodes
    //////////////////////////////////////////////////
    localparam logic [6:0] opcOp     = 7'b0110011;
    localparam logic [6:0] opcOpImm  = 7'b0010011;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcLui    = 7'b0110111;
    localparam logic [6:0] opcAuipc  = 7'b0010111;
    localparam logic [6:0] opcJal    = 7'b1101111;
    localparam logic [6:0] opcJalr   = 7'b1100111;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] f3AddSub = 3'd0;
    localparam logic [2:0] f3Sll    = 3'd1;
    localparam logic [2:0] f3Slt    = 3'd2;
    localparam logic [2:0] f3Sltu   = 3'd3;
    localparam logic [2:0] f3Xor    = 3'd4;
    localparam logic [2:0] f3SrlSra = 3'd5;
    localparam logic [2:0] f3Or     = 3'd6;
    localparam logic [2:0] f3And    = 3'd7;

    // funct3 for branches
    localparam logic [2:0] f3Beq  = 3'd0;
    localparam logic [2:0] f3Bne  = 3'd1;
    localparam logic [2:0] f3Blt  = 3'd4;
    localparam logic [2:0] f3Bge  = 3'd5;
    localparam logic [2:0] f3Bltu = 3'd6;
    localparam logic [2:0] f3Bgeu = 3'd7;

    //////////////////////////////////////////////////
    // Instruction formats, MSB first
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFormat;

    typedef struct packed {
        logic [11:0] imm11to0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFormat;

    typedef struct packed {
        logic [6:0] imm11to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4to0;
        logic [6:0] opcode;
    } sFormat;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFormat;

    typedef struct packed {
        logic [19:0] imm31to12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFormat;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFormat;

    // One word, six views
    typedef union packed {
        rFormat r;
        iFormat i;
        sFormat s;
        bFormat b;
        uFormat u;
        jFormat j;
    } instrWord;

endpackage

// ==== logic/idControl.sv ====
`timescale 1ns/100ps

module idControl import rv32iPkg::*; (
    input  logic [dataWidth-1:0]    instruction,
    output logic                    rdWrEn,
    output logic                    aluSrcSel,
    output logic [aluOpWidth-1:0]   aluOp,
    output logic [dataWidth-1:0]    immediate,
    output logic                    branchEn,
    output logic [regAddrWidth-1:0] rdAddress,
    output logic [regAddrWidth-1:0] rs1Address,
    output logic [regAddrWidth-1:0] rs2Address
);

    instrWord             instr;
    logic                 altBit;
    logic [dataWidth-1:0] immI;
    logic [dataWidth-1:0] immS;
    logic [dataWidth-1:0] immB;
    logic [dataWidth-1:0] immU;
    logic [dataWidth-1:0] immJ;

    assign instr = instruction;

    // Bit 30 selects SUB and SRA
    assign altBit = instr.r.funct7[5];

    // Source fields sit at the same place in every format
    assign rs1Address = instr.r.rs1;
    assign rs2Address = instr.r.rs2;
    assign rdAddress  = rdWrEn ? instr.r.rd : '0;

    ////////////////////////////////////////////////////
    // Immediate assembly
    ////////////////////////////////////////////////////
    assign immI = {{20{instr.i.imm11to0[11]}}, instr.i.imm11to0};
    assign immS = {{20{instr.s.imm11to5[6]}}, instr.s.imm11to5, instr.s.imm4to0};
    assign immB = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                   instr.b.imm10to5, instr.b.imm4to1, 1'b0};
    assign immU = {instr.u.imm31to12, 12'b0};
    assign immJ = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                   instr.j.imm11, instr.j.imm10to1, 1'b0};

    // SUB only exists for the register form
    function automatic logic [aluOpWidth-1:0] aluFromFunct3(
        input logic [2:0] funct3,
        input logic       alt,
        input logic       regOp
    );
        logic [aluOpWidth-1:0] op;
        case (funct3)
            f3AddSub: op = (regOp && alt) ? aluOpSub : aluOpAdd;
            f3Sll:    op = aluOpSll;
            f3Slt:    op = aluOpSlt;
            f3Sltu:   op = aluOpSltu;
            f3Xor:    op = aluOpXor;
            f3SrlSra: op = alt ? aluOpSra : aluOpSrl;
            f3Or:     op = aluOpOr;
            f3And:    op = aluOpAnd;
            default:  op = aluOpAdd;
        endcase
        return op;
    endfunction

    ////////////////////////////////////////////////////
    // Main decode
    ////////////////////////////////////////////////////
    always_comb begin
        // Defaults give a no-op
        rdWrEn    = 1'b0;
        aluSrcSel = 1'b0;
        aluOp     = aluOpAdd;
        immediate = '0;
        branchEn  = 1'b0;

        case (instr.r.opcode)
            opcOp: begin
                rdWrEn = 1'b1;
                aluOp  = aluFromFunct3(instr.r.funct3, altBit, 1'b1);
            end
            opcOpImm: begin
                rdWrEn    = 1'b1;
                aluSrcSel = 1'b1;
                immediate = immI;
                aluOp     = aluFromFunct3(instr.i.funct3, altBit, 1'b0);
            end
            opcLoad: begin
                rdWrEn    = 1'b1;
                aluSrcSel = 1'b1;
                immediate = immI;
            end
            opcStore: begin
                aluSrcSel = 1'b1;
                immediate = immS;
            end
            opcBranch: begin
                branchEn  = 1'b1;
                immediate = immB;
                // Compare in the ALU, target adder lives in execute
                case (instr.b.funct3)
                    f3Beq, f3Bne:   aluOp = aluOpSub;
                    f3Blt, f3Bge:   aluOp = aluOpSlt;
                    f3Bltu, f3Bgeu: aluOp = aluOpSltu;
                    default:        aluOp = aluOpAdd;
                endcase
            end
            opcLui: begin
                rdWrEn    = 1'b1;
                aluSrcSel = 1'b1;
                immediate = immU;
                aluOp     = aluOpPassB;
            end
            opcAuipc: begin
                rdWrEn    = 1'b1;
                aluSrcSel = 1'b1;
                immediate = immU;
            end
            opcJal: begin
                rdWrEn    = 1'b1;
                aluSrcSel = 1'b1;
                branchEn  = 1'b1;
                immediate = immJ;
            end
            opcJalr: begin
                rdWrEn    = 1'b1;
                aluSrcSel = 1'b1;
                branchEn  = 1'b1;
                immediate = immI;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== logic/idRegFile.sv ====
`timescale 1ns/100ps

module idRegFile import rv32iPkg::*; (
    input  logic                    Clk_100MHz,
    input  logic                    rst,
    input  logic [regAddrWidth-1:0] rs1Address,
    input  logic [regAddrWidth-1:0] rs2Address,
    input  logic [regAddrWidth-1:0] rdAddress,
    input  logic [dataWidth-1:0]    rdWrData,
    input  logic                    rdWrEn,
    output logic [dataWidth-1:0]    rs1Data,
    output logic [dataWidth-1:0]    rs2Data
);

    logic [dataWidth-1:0] regs [regDepth];
    logic                 wrValid;

    // x0 is never written
    assign wrValid = rdWrEn && (rdAddress != '0);

    ////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////
    always_ff @(posedge Clk_100MHz) begin
        if (rst) begin
            for (int i = 0; i < regDepth; i++) begin
                regs[i] <= '0;
            end
        end else if (wrValid) begin
            regs[rdAddress] <= rdWrData;
        end
    end

    ////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////
    // Bypass the write so decode sees writeback in the same cycle
    assign rs1Data = (rs1Address == '0)                    ? '0 :
                     (wrValid && rdAddress == rs1Address)  ? rdWrData :
                                                             regs[rs1Address];

    assign rs2Data = (rs2Address == '0)                    ? '0 :
                     (wrValid && rdAddress == rs2Address)  ? rdWrData :
                                                             regs[rs2Address];

    // Entry 0 holds zero from reset onwards
    x0StaysZero: assert property (
        @(posedge Clk_100MHz) disable iff (rst)
        regs[0] == '0
    ) else $error("idRegFile: x0 holds %h", regs[0]);

endmodule

// ==== logic/idStage.sv ====
`timescale 1ns/100ps

module idStage import rv32iPkg::*; (
    input  logic                    Clk_100MHz,
    input  logic                    rst,

    // From fetch
    input  logic [dataWidth-1:0]    ifPc,
    input  logic [dataWidth-1:0]    ifInstruction,

    // From writeback
    input  logic [regAddrWidth-1:0] wbRdAddress,
    input  logic [dataWidth-1:0]    wbRdData,
    input  logic                    wbWrEn,

    output logic [dataWidth-1:0]    idPc,
    output logic                    idRdWrEn,
    output logic                    idAluSrcSel,
    output logic [aluOpWidth-1:0]   idAluOp,
    output logic [dataWidth-1:0]    idImmediate,
    output logic                    idBranchEn,
    output logic [regAddrWidth-1:0] idRdAddress,
    output logic [dataWidth-1:0]    idRs1Data,
    output logic [dataWidth-1:0]    idRs2Data
);

    logic [regAddrWidth-1:0] rs1Address;
    logic [regAddrWidth-1:0] rs2Address;

    idControl control0 (
        .instruction (ifInstruction),
        .rdWrEn      (idRdWrEn),
        .aluSrcSel   (idAluSrcSel),
        .aluOp       (idAluOp),
        .immediate   (idImmediate),
        .branchEn    (idBranchEn),
        .rdAddress   (idRdAddress),
        .rs1Address  (rs1Address),
        .rs2Address  (rs2Address)
    );

    idRegFile regFile0 (
        .Clk_100MHz (Clk_100MHz),
        .rst        (rst),
        .rs1Address (rs1Address),
        .rs2Address (rs2Address),
        .rdAddress  (wbRdAddress),
        .rdWrData   (wbRdData),
        .rdWrEn     (wbWrEn),
        .rs1Data    (idRs1Data),
        .rs2Data    (idRs2Data)
    );

    ////////////////////////////////////////////////////
    // PC pipeline register
    ////////////////////////////////////////////////////
    always_ff @(posedge Clk_100MHz) begin
        if (rst) begin
            idPc <= '0;
        end else begin
            idPc <= ifPc;
        end
    end

endmodule

// ==== dv/tbClockGen.sv ====
`timescale 1ns/100ps

module tbClockGen (
    output logic Clk_100MHz
);

    // 10 ns period
    localparam int halfPeriod = 5;

    initial begin
        Clk_100MHz = 1'b0;
        forever begin
            #halfPeriod Clk_100MHz = ~Clk_100MHz;
        end
    end

endmodule

// ==== dv/idStageTb.sv ====
`timescale 1ns/100ps

module idStageTb import rv32iPkg::*; ();

    // Roughly twice the summed length of all tests
    localparam int timeoutCycles = 400;
    localparam int settleNs      = 2;

    logic                    Clk_100MHz;
    logic                    rst;
    logic [dataWidth-1:0]    ifPc;
    logic [dataWidth-1:0]    ifInstruction;
    logic [regAddrWidth-1:0] wbRdAddress;
    logic [dataWidth-1:0]    wbRdData;
    logic                    wbWrEn;
    logic [dataWidth-1:0]    idPc;
    logic                    idRdWrEn;
    logic                    idAluSrcSel;
    logic [aluOpWidth-1:0]   idAluOp;
    logic [dataWidth-1:0]    idImmediate;
    logic                    idBranchEn;
    logic [regAddrWidth-1:0] idRdAddress;
    logic [dataWidth-1:0]    idRs1Data;
    logic [dataWidth-1:0]    idRs2Data;

    logic [31:0] rngState;
    string       testName;
    int          cycleCount = 0;

    tbClockGen clockGen0 (.Clk_100MHz(Clk_100MHz));

    idStage dut0 (.*);

    //////////////////////////////////////////////////
    // Random data and instruction builders
    //////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic instrWord makeR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
        instrWord w;
        w.r = '{f7, rs2, rs1, f3, rd, opcOp};
        return w;
    endfunction

    function automatic instrWord makeI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] opc);
        instrWord w;
        w.i = '{imm, rs1, f3, rd, opc};
        return w;
    endfunction

    function automatic instrWord makeS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        instrWord w;
        w.s = '{imm[11:5], rs2, rs1, 3'd2, imm[4:0], opcStore};
        return w;
    endfunction

    // imm[0] is dropped by the encoding
    function automatic instrWord makeB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
        instrWord w;
        w.b = '{imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcBranch};
        return w;
    endfunction

    function automatic instrWord makeU(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        instrWord w;
        w.u = '{imm, rd, opc};
        return w;
    endfunction

    function automatic instrWord makeJ(logic [20:0] imm, logic [4:0] rd);
        instrWord w;
        w.j = '{imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
        return w;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic stopOnFailure();
        $display("Testbench failed");
        $fatal(1, "Stopping at first failure");
    endtask

    task automatic checkData(string what, logic [dataWidth-1:0] exp, logic [dataWidth-1:0] act);
        if (act !== exp) begin
            $display("Error: %s %s expected %h actual %h", testName, what, exp, act);
            stopOnFailure();
        end
    endtask

    task automatic checkAluOp(string what, logic [aluOpWidth-1:0] exp,
                              logic [aluOpWidth-1:0] act);
        if (act !== exp) begin
            $display("Error: %s %s expected %0d actual %0d", testName, what, exp, act);
            stopOnFailure();
        end
    endtask

    task automatic checkAddr(string what, logic [regAddrWidth-1:0] exp,
                             logic [regAddrWidth-1:0] act);
        if (act !== exp) begin
            $display("Error: %s %s expected %0d actual %0d", testName, what, exp, act);
            stopOnFailure();
        end
    endtask

    task automatic checkBit(string what, logic exp, logic act);
        if (act !== exp) begin
            $display("Error: %s %s expected %b actual %b", testName, what, exp, act);
            stopOnFailure();
        end
    endtask

    task automatic checkDecode(logic wr, logic src, logic [aluOpWidth-1:0] op,
                               logic [dataWidth-1:0] imm, logic br,
                               logic [regAddrWidth-1:0] rd);
        checkBit("rdWrEn", wr, idRdWrEn);
        checkBit("aluSrcSel", src, idAluSrcSel);
        checkAluOp("aluOp", op, idAluOp);
        checkData("immediate", imm, idImmediate);
        checkBit("branchEn", br, idBranchEn);
        checkAddr("rdAddress", rd, idRdAddress);
    endtask

    task automatic applyInstr(instrWord w);
        @(negedge Clk_100MHz);
        ifInstruction = w;
        #settleNs;
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    task automatic testResetState();
        testName = "reset state";
        checkData("idPc", '0, idPc);
        for (int a = 0; a < regDepth; a++) begin
            applyInstr(makeR(7'd0, 5'(a), 5'(a), 3'd0, 5'd1));
            checkData("rs1Data", '0, idRs1Data);
            checkData("rs2Data", '0, idRs2Data);
        end
    endtask

    task automatic testWriteReadBack();
        logic [dataWidth-1:0] value;
        testName = "write and read back";
        for (int a = 0; a < regDepth; a++) begin
            value = nextRandom();
            @(negedge Clk_100MHz);
            wbWrEn      = 1'b1;
            wbRdAddress = 5'(a);
            wbRdData    = value;
            @(negedge Clk_100MHz);
            wbWrEn        = 1'b0;
            ifInstruction = makeR(7'd0, 5'(a), 5'(a), 3'd0, 5'd1);
            #settleNs;
            // x0 ignores the write
            checkData("rs1Data", (a == 0) ? '0 : value, idRs1Data);
            checkData("rs2Data", (a == 0) ? '0 : value, idRs2Data);
        end
    endtask

    task automatic testWriteThrough();
        logic [dataWidth-1:0] value;
        testName = "write-through";
        for (int n = 3; n < regDepth; n += 7) begin
            value = nextRandom();
            @(negedge Clk_100MHz);
            wbWrEn        = 1'b1;
            wbRdAddress   = 5'(n);
            wbRdData      = value;
            ifInstruction = makeR(7'd0, 5'(n), 5'(n), 3'd0, 5'd1);
            #settleNs;
            checkData("rs1Data", value, idRs1Data);
            checkData("rs2Data", value, idRs2Data);
        end
        @(negedge Clk_100MHz);
        wbWrEn = 1'b0;
    endtask

    task automatic testAluDecode();
        logic [aluOpWidth-1:0] baseOps [8];
        logic [aluOpWidth-1:0] expOp;
        logic [31:0]           rnd;
        logic [11:0]           imm;
        logic [4:0]            rd;
        baseOps  = '{aluOpAdd, aluOpSll, aluOpSlt, aluOpSltu, aluOpXor, aluOpSrl, aluOpOr,
                     aluOpAnd};
        testName = "ALU decode";
        // R-type, alternate encodings only for ADD/SUB and SRL/SRA
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f3 == 0 || f3 == 5) begin
                    expOp = (alt == 0) ? baseOps[f3] : (f3 == 0) ? aluOpSub : aluOpSra;
                    rd    = 5'(f3 + 8 * alt + 1);
                    applyInstr(makeR({1'b0, 1'(alt), 5'b0}, 5'(rd + 1), rd, 3'(f3), rd));
                    checkDecode(1'b1, 1'b0, expOp, '0, 1'b0, rd);
                end
            end
        end
        // OP-IMM, second pass uses negative immediates
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                rnd = nextRandom();
                rd  = rnd[19:15];
                if (f3 == 1 || f3 == 5) begin
                    imm = {1'b0, 1'(alt == 1 && f3 == 5), 5'b0, rnd[4:0]};
                end else begin
                    imm = {1'(alt), rnd[10:0]};
                end
                expOp = (f3 == 5 && alt == 1) ? aluOpSra : baseOps[f3];
                applyInstr(makeI(imm, rnd[24:20], 3'(f3), rd, opcOpImm));
                checkDecode(1'b1, 1'b1, expOp, {{20{imm[11]}}, imm}, 1'b0, rd);
            end
        end
    endtask

    task automatic testOtherFormats();
        logic [2:0]            brF3 [6];
        logic [aluOpWidth-1:0] brOps [6];
        logic [31:0]           rnd;
        brF3  = '{f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu};
        brOps = '{aluOpSub, aluOpSub, aluOpSlt, aluOpSlt, aluOpSltu, aluOpSltu};
        testName = "store";
        rnd = nextRandom();
        applyInstr(makeS(rnd[11:0], rnd[16:12], rnd[21:17]));
        checkDecode(1'b0, 1'b1, aluOpAdd, {{20{rnd[11]}}, rnd[11:0]}, 1'b0, '0);
        testName = "load";
        applyInstr(makeI(rnd[31:20], rnd[16:12], 3'd2, rnd[21:17], opcLoad));
        checkDecode(1'b1, 1'b1, aluOpAdd, {{20{rnd[31]}}, rnd[31:20]}, 1'b0, rnd[21:17]);
        testName = "branch";
        for (int k = 0; k < 6; k++) begin
            rnd = nextRandom();
            applyInstr(makeB({rnd[12:1], 1'b0}, rnd[17:13], rnd[22:18], brF3[k]));
            checkDecode(1'b0, 1'b0, brOps[k], {{19{rnd[12]}}, rnd[12:1], 1'b0}, 1'b1, '0);
        end
        testName = "LUI";
        rnd = nextRandom();
        applyInstr(makeU(rnd[31:12], rnd[4:0], opcLui));
        checkDecode(1'b1, 1'b1, aluOpPassB, {rnd[31:12], 12'b0}, 1'b0, rnd[4:0]);
        testName = "AUIPC";
        applyInstr(makeU(rnd[31:12], rnd[9:5], opcAuipc));
        checkDecode(1'b1, 1'b1, aluOpAdd, {rnd[31:12], 12'b0}, 1'b0, rnd[9:5]);
        testName = "JAL";
        rnd = nextRandom();
        applyInstr(makeJ({rnd[20:1], 1'b0}, rnd[25:21]));
        checkDecode(1'b1, 1'b1, aluOpAdd, {{11{rnd[20]}}, rnd[20:1], 1'b0}, 1'b1, rnd[25:21]);
        testName = "JALR";
        applyInstr(makeI(rnd[11:0], rnd[16:12], 3'd0, rnd[30:26], opcJalr));
        checkDecode(1'b1, 1'b1, aluOpAdd, {{20{rnd[11]}}, rnd[11:0]}, 1'b1, rnd[30:26]);
        // Unknown opcode behaves as a no-op
        testName = "undefined opcode";
        rnd = nextRandom();
        applyInstr(makeI(rnd[31:20], rnd[19:15], rnd[14:12], rnd[11:7], 7'b1111111));
        checkDecode(1'b0, 1'b0, aluOpAdd, '0, 1'b0, '0);
    endtask

    task automatic testPcPipeline();
        logic [dataWidth-1:0] lastPc;
        testName = "PC pipeline";
        @(negedge Clk_100MHz);
        ifPc = nextRandom();
        for (int k = 0; k < 16; k++) begin
            lastPc = ifPc;
            @(negedge Clk_100MHz);
            checkData("idPc", lastPc, idPc);
            ifPc = nextRandom();
        end
        // Reset in the middle of the stream
        rst = 1'b1;
        @(negedge Clk_100MHz);
        rst = 1'b0;
        checkData("idPc after reset", '0, idPc);
        lastPc = ifPc;
        @(negedge Clk_100MHz);
        checkData("idPc", lastPc, idPc);
    endtask

    //////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////
    always @(posedge Clk_100MHz) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: tests did not finish within %0d cycles", timeoutCycles);
            stopOnFailure();
        end
    end

    initial begin
        rngState      = 32'heaa9_1acc;
        rst           = 1'b1;
        ifPc          = 32'h0000_1000;
        ifInstruction = makeI(12'd0, 5'd0, 3'd0, 5'd0, opcOpImm);
        wbRdAddress   = '0;
        wbRdData      = '0;
        wbWrEn        = 1'b0;
        repeat (10) @(negedge Clk_100MHz);
        rst = 1'b0;
        testResetState();
        testWriteReadBack();
        testWriteThrough();
        testAluDecode();
        testOtherFormats();
        testPcPipeline();
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/rv32iPkg.sv
logic/idControl.sv
logic/idRegFile.sv
logic/idStage.sv
dv/tbClockGen.sv
dv/idStageTb.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - logic/rv32iPkg.sv
  - logic/idControl.sv
  - logic/idRegFile.sv
  - logic/idStage.sv
  - target: simulation
    files:
      - dv/tbClockGen.sv
      - dv/idStageTb.sv
